/* all.f */
verilog/cpu16_mem_pkg.sv
verilog/cpu16_isa_pkg.sv
verilog/cpu16_if.sv
verilog/cpu16_alu.sv
verilog/cpu16_core.sv
verilog/cpu16_memory.sv
verilog/cpu16_system.sv
dv/cpu16_system_tb.sv

/* dv/cpu16_system_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_system_tb import cpu16_mem_pkg::*; ();

  localparam int period_ns     = 100;
  localparam int data_words    = 512;
  localparam int settle_cycles = 20;

  logic  clk;
  logic  reset;
  logic  halt;
  logic  load_write;
  addr_t load_address;
  word_t load_data;
  logic  busy;
  logic  write;
  addr_t address;
  word_t data_out;

  word_t testdata [data_words];
  int    prog_count;
  int    store_base;
  int    store_count;
  int    tail;
  int    halt_cycles;
  int    budget;
  int    limit_cycles;
  addr_t fetch_expected;
  int    store_index;
  int    error_count;
  addr_t exp_addr;
  word_t exp_data;

  cpu16_system cpu16_system_i (
    .clk          (clk),
    .reset        (reset),
    .halt         (halt),
    .load_write   (load_write),
    .load_address (load_address),
    .load_data    (load_data),
    .busy         (busy),
    .address      (address),
    .data_out     (data_out),
    .write        (write)
  );

  always #(period_ns / 2) clk = ~clk;

  // group of the program that produces a given store
  function automatic string test_name_for(input int idx);
    if (idx < 6)
      return "reg_arith";
    else if (idx < 9)
      return "inline_operands";
    else if (idx < 17)
      return "stack_indexed";
    else if (idx < 21)
      return "branches";
    else
      return "store_jump";
  endfunction

  task automatic print_summary();
    $display("errors: %0d, stores checked: %0d of %0d", error_count, store_index, store_count);
  endtask

  // bus monitor samples mid-cycle
  always @(negedge clk) begin
    if (reset === 1'b0) begin
      if (halt && (busy !== 1'b1 || write !== 1'b0)) begin
        $display("core was active while halt was high (busy=%b write=%b)", busy, write);
        error_count++;
      end
      if (write === 1'b1) begin
        if (store_index >= store_count) begin
          $display("extra store beyond the %0d expected: [%h]=%h",
                   store_count, address, data_out);
          error_count++;
        end else begin
          exp_addr = testdata[store_base + 1 + 2 * store_index];
          exp_data = testdata[store_base + 2 + 2 * store_index];
          if (address !== exp_addr || data_out !== exp_data) begin
            $display("mismatch %s store %0d: expected [%h]=%h, actual [%h]=%h",
                     test_name_for(store_index), store_index, exp_addr, exp_data,
                     address, data_out);
            error_count++;
          end
        end
        store_index++;
      end
    end
  end

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    halt         = 1'b1;
    load_write   = 1'b0;
    load_address = '0;
    load_data    = '0;
    store_index  = 0;
    store_count  = 0;
    error_count  = 0;
    $readmemh("dv/cpu16_testdata.hex", testdata);
    if ($isunknown(testdata[0])) begin
      $display("test data file is missing or holds no program word count");
      error_count++;
    end else begin
      prog_count     = testdata[0];
      store_base     = 1 + 2 * prog_count;
      store_count    = testdata[store_base];
      tail           = store_base + 1 + 2 * store_count;
      fetch_expected = testdata[tail];
      halt_cycles    = testdata[tail + 1];
      budget         = testdata[tail + 2];
      limit_cycles   = 2 + prog_count + halt_cycles + budget;

      fork
        begin
          #(limit_cycles * period_ns);
          $display("timeout after %0d cycles, only %0d of %0d stores seen",
                   limit_cycles, store_index, store_count);
          error_count++;
          print_summary();
          $display("Something failed");
          $finish;
        end
      join_none

      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      if (busy !== 1'b1 || write !== 1'b0) begin
        $display("mismatch reset: expected busy=1 write=0, actual busy=%b write=%b",
                 busy, write);
        error_count++;
      end

      // program goes in through the load port while halted
      for (int i = 0; i < prog_count; i++) begin
        @(posedge clk);
        load_write   <= 1'b1;
        load_address <= testdata[1 + 2 * i];
        load_data    <= testdata[2 + 2 * i];
      end
      @(posedge clk);
      load_write <= 1'b0;
      repeat (halt_cycles) @(posedge clk);
      halt <= 1'b0;

      // first fetch after release
      @(negedge clk);
      while (busy !== 1'b0)
        @(negedge clk);
      if (address !== fetch_expected) begin
        $display("mismatch halt_release: expected fetch address %h, actual %h",
                 fetch_expected, address);
        error_count++;
      end

      while (store_index < store_count)
        @(negedge clk);
      // keep watching for stray stores
      repeat (settle_cycles) @(negedge clk);
    end

    print_summary();
    if (error_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/cpu16_testdata.hex */
// program: word count, then rom address / instruction word pairs
// stores: count, then address / data pairs; last line: fetch address, halt cycles, budget
0037
// register and immediate arithmetic
8000 C034  8001 C112  8002 0061  8003 3010  8004 0168  8005 3111
8006 0118  8007 3112  8008 0030  8009 3013  800A 0158  800B 3114
800C E074  800D 3015
// inline immediate and memory operands
800E 1A40  800F F000  8010 1A60  8011 2345  8012 3216  8013 C301
8014 1B70  8015 0100  8016 3317  8017 6A60  8018 0016  8019 3218
// stack and indexed addressing
801A 1E40  801B 0200  801C 5206  801D 5306  801E 4C06  801F 4D06
8020 3419  8021 351A  8022 55F0  8023 49F0  8024 311B  8025 5006
8026 0966  8027 311C
// countdown loop and a fall-through branch
8028 C203  8029 3220  802A EA01  802B 82FD  802C 8C02  802D C355
802E 3321
// store-and-jump, a store that must be skipped, then a spin loop
802F 1C40  8030 8040  8031 C5A5  8032 7520  8033 3522
8040 C177  8041 3123  8042 87FF
// expected stores
0017
0010 0046  0011 FFCC  0012 FF8A  0013 008C  0014 8AFF  0015 0100
0016 1345  0017 0102  0018 268A
01FF 268A  01FE 0102  0019 0102  001A 268A  00FE 268A  001B 268A
01FF 0100  001C 278A
0020 0003  0020 0002  0020 0001  0021 0055
0100 00A5  0023 0077
// first fetch address, halt cycles after loading, execution cycle budget
8000 0004 0200

/* verilog/cpu16_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_alu import cpu16_isa_pkg::*; #(
  parameter int data_width = 16
) (
  alu_if.unit alu
);

  localparam int half = data_width / 2;
  localparam logic [data_width:0] one = {{data_width{1'b0}}, 1'b1};

  logic [data_width-1:0] a;
  logic [data_width:0]   a_ext;
  logic [data_width:0]   b_ext;
  logic [data_width:0]   cin_ext;
  logic [data_width:0]   result;

  assign a       = alu.a;
  assign a_ext   = {1'b0, alu.a};
  assign b_ext   = {1'b0, alu.b};
  assign cin_ext = {{data_width{1'b0}}, alu.carry_in};

  // top bit of result is the carry or borrow
  always_comb begin
    case (alu.op)
      op_pass_a: result = a_ext;
      op_or:     result = a_ext | b_ext;
      op_and:    result = a_ext & b_ext;
      op_xor:    result = a_ext ^ b_ext;
      op_inc:    result = a_ext + one;
      op_dec:    result = a_ext - one;
      // shifted out bit lands in carry
      op_shl:    result = {a, 1'b0};
      op_shr:    result = {a[0], 1'b0, a[data_width-1:1]};
      op_load_b: result = b_ext;
      op_not_a:  result = {1'b0, ~a};
      op_clear:  result = '0;
      op_swap:   result = {1'b0, a[half-1:0], a[data_width-1:half]};
      op_add:    result = a_ext + b_ext;
      op_sub:    result = a_ext - b_ext;
      op_adc:    result = a_ext + b_ext + cin_ext;
      op_sbb:    result = a_ext - b_ext - cin_ext;
      default:   result = a_ext;
    endcase
  end

  assign alu.y         = result[data_width-1:0];
  assign alu.carry_out = result[data_width];

endmodule

`default_nettype wire

/* verilog/cpu16_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_core
  import cpu16_isa_pkg::*;
  import cpu16_mem_pkg::*;
#(
  parameter int data_width = word_w
) (
  input  wire       clk,
  input  wire       reset,
  input  wire       halt,
  output logic      busy,
  mem_bus_if.master bus
);

  localparam word_t one = word_t'(1);

  word_t       regs [8];
  word_t       ir;
  core_state_t state;
  alu_op_t     aluop;
  logic        carry;
  logic        zero;
  logic        neg;
  // next decode pass takes the bus word as an operand address
  logic        mem_indirect;

  // latched instruction fields for compute
  logic [reg_w-1:0] rdest;
  logic [reg_w-1:0] rsrc;
  logic             b_const;
  logic             b_load;

  // fields of the word being decoded
  ir_class_t        ir_class;
  logic [reg_w-1:0] d_dest;
  logic [reg_w-1:0] d_src;
  logic [reg_w-1:0] d_jump;
  alu_op_t          d_op;
  alu_op_t          d_imm_op;
  word_t            d_base;
  word_t            d_offset;
  word_t            store_base;
  word_t            branch_offset;
  addr_t            zp_addr;
  logic             sp_base;
  logic [2:0]       flags;
  logic [2:0]       flag_en;
  logic             polarity;
  logic             branch_taken;

  alu_if #(.data_width(data_width)) alu_bus ();

  cpu16_alu #(.data_width(data_width)) alu_i (
    .alu (alu_bus.unit)
  );

  assign rdest   = ir[dest_lsb +: reg_w];
  assign rsrc    = ir[src_lsb +: reg_w];
  assign b_const = ir[b_const_bit];
  assign b_load  = ir[b_load_bit];

  assign alu_bus.a        = regs[rdest];
  assign alu_bus.b        = b_const ? word_t'(ir[imm8_w-1:0]) :
                            b_load  ? bus.rdata : regs[rsrc];
  assign alu_bus.op       = aluop;
  assign alu_bus.carry_in = carry;

  assign d_dest   = bus.rdata[dest_lsb +: reg_w];
  assign d_src    = bus.rdata[src_lsb +: reg_w];
  assign d_jump   = bus.rdata[jump_lsb +: reg_w];
  assign d_op     = alu_op_t'(bus.rdata[op_lsb +: $bits(alu_op_t)]);
  assign d_imm_op = alu_op_t'(bus.rdata[imm_op_lsb +: $bits(alu_op_t)]);
  assign d_base   = regs[d_src];
  assign sp_base  = (d_src == reg_sp);
  assign zp_addr  = addr_t'(bus.rdata[imm8_w-1:0]);

  // stores through the stack pointer pre-decrement
  assign store_base = sp_base ? d_base - one : d_base;

  assign d_offset = {{($bits(word_t) - offset_w){bus.rdata[offset_lsb + offset_w - 1]}},
                     bus.rdata[offset_lsb +: offset_w]};
  assign branch_offset = {{($bits(word_t) - imm8_w){bus.rdata[imm8_w-1]}},
                          bus.rdata[imm8_w-1:0]};

  assign flags        = {neg, zero, carry};
  assign flag_en      = bus.rdata[flag_en_lsb +: 3];
  assign polarity     = bus.rdata[polarity_bit];
  assign branch_taken = |(flag_en & ~(flags ^ {3{polarity}}));

  always_comb begin
    casez (bus.rdata)
      16'b00000???_0???????: ir_class = cls_alu_reg;
      16'b00001???_0???????: ir_class = cls_alu_ind;
      16'b00011???_0????000: ir_class = cls_alu_imm16;
      16'b01101???_0????000: ir_class = cls_alu_mem;
      16'b11??????_????????: ir_class = cls_alu_imm8;
      16'b00101???_????????: ir_class = cls_load_zp;
      16'b00110???_????????: ir_class = cls_store_zp;
      16'b01001???_????????: ir_class = cls_load_idx;
      16'b01010???_????????: ir_class = cls_store_idx;
      16'b01110???_00??????: ir_class = cls_store_jump;
      16'b1000????_????????: ir_class = cls_branch;
      default:               ir_class = cls_invalid;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= st_reset;
      busy         <= 1'b1;
      bus.write    <= 1'b0;
      mem_indirect <= 1'b0;
      carry        <= 1'b0;
      zero         <= 1'b0;
      neg          <= 1'b0;
    end else begin
      case (state)
        st_reset: begin
          regs[reg_ip] <= reset_vector;
          bus.write    <= 1'b0;
          state        <= st_select;
        end
        // fetch unless halted
        st_select: begin
          bus.write <= 1'b0;
          if (halt) begin
            busy <= 1'b1;
          end else begin
            busy         <= 1'b0;
            bus.address  <= regs[reg_ip];
            regs[reg_ip] <= regs[reg_ip] + one;
            state        <= st_decode;
          end
        end
        st_decode: begin
          if (mem_indirect) begin
            // inline word is the operand address
            mem_indirect <= 1'b0;
            bus.address  <= bus.rdata;
            state        <= st_compute;
          end else begin
            ir <= bus.rdata;
            case (ir_class)
              cls_alu_reg: begin
                aluop <= d_op;
                state <= st_compute;
              end
              cls_alu_ind: begin
                bus.address <= d_base;
                aluop       <= d_op;
                if (sp_base)
                  regs[reg_sp] <= d_base + one;
                state <= st_compute;
              end
              cls_alu_imm16: begin
                bus.address  <= regs[reg_ip];
                regs[reg_ip] <= regs[reg_ip] + one;
                aluop        <= d_op;
                state        <= st_compute;
              end
              cls_alu_mem: begin
                bus.address  <= regs[reg_ip];
                regs[reg_ip] <= regs[reg_ip] + one;
                aluop        <= d_op;
                mem_indirect <= 1'b1;
              end
              cls_alu_imm8: begin
                aluop <= d_imm_op;
                state <= st_compute;
              end
              cls_load_zp: begin
                bus.address <= zp_addr;
                aluop       <= op_load_b;
                state       <= st_compute;
              end
              cls_store_zp: begin
                bus.address <= zp_addr;
                bus.wdata   <= regs[d_dest];
                bus.write   <= 1'b1;
                state       <= st_select;
              end
              cls_load_idx: begin
                bus.address <= d_base + d_offset;
                aluop       <= op_load_b;
                if (sp_base)
                  regs[reg_sp] <= d_base + one;
                state <= st_compute;
              end
              cls_store_idx: begin
                bus.address <= store_base + d_offset;
                bus.wdata   <= regs[d_dest];
                bus.write   <= 1'b1;
                if (sp_base)
                  regs[reg_sp] <= store_base;
                state <= st_select;
              end
              cls_store_jump: begin
                bus.address  <= store_base;
                bus.wdata    <= regs[d_dest];
                bus.write    <= 1'b1;
                if (sp_base)
                  regs[reg_sp] <= store_base;
                regs[reg_ip] <= regs[d_jump];
                state        <= st_select;
              end
              cls_branch: begin
                if (branch_taken)
                  regs[reg_ip] <= regs[reg_ip] + branch_offset;
                state <= st_select;
              end
              // undecodable word restarts at the reset vector
              default: state <= st_reset;
            endcase
          end
        end
        st_compute: begin
          regs[rdest] <= alu_bus.y;
          if (aluop[carry_op_bit])
            carry <= alu_bus.carry_out;
          zero  <= ~|alu_bus.y;
          neg   <= alu_bus.y[data_width-1];
          state <= st_select;
        end
        default: state <= st_reset;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/cpu16_if.sv */
`timescale 1ns/1ps
`default_nettype none

// single word bus with combinational read and write strobe
interface mem_bus_if import cpu16_mem_pkg::*; ();

  addr_t address;
  word_t rdata;
  word_t wdata;
  logic  write;

  modport master (output address, output wdata, output write, input rdata);
  modport slave (input address, input wdata, input write, output rdata);

endinterface

interface alu_if import cpu16_isa_pkg::*; #(
  parameter int data_width = 16
) ();

  logic [data_width-1:0] a;
  logic [data_width-1:0] b;
  alu_op_t               op;
  logic                  carry_in;
  logic [data_width-1:0] y;
  logic                  carry_out;

  modport user (output a, output b, output op, output carry_in,
                input y, input carry_out);
  modport unit (input a, input b, input op, input carry_in,
                output y, output carry_out);

endinterface

`default_nettype wire

/* verilog/cpu16_isa_pkg.sv */
`default_nettype none

package cpu16_isa_pkg;

  // instruction encodings
  //   00000aaa 0oooobbb   a = a op b
  //   00001aaa 0oooobbb   a = a op [b]
  //   00011aaa 0oooo000   a = a op imm16 (next word)
  //   01101aaa 0oooo000   a = a op [imm16] (next word is the address)
  //   11ooo aaa iiiiiiii  a = a op imm8 with op = {1,ooo}
  //   00101aaa zzzzzzzz   a = [zp]
  //   00110aaa zzzzzzzz   [zp] = a
  //   01001aaa fffffbbb   a = [b + f]
  //   01010aaa fffffbbb   [b + f] = a
  //   01110aaa 00cccbbb   [b] = a then ip = c
  //   1000pnzc dddddddd   ip += d when an enabled flag equals p

  // field positions
  localparam int reg_w        = 3;
  localparam int dest_lsb     = 8;
  localparam int src_lsb      = 0;
  localparam int jump_lsb     = 3;
  localparam int op_lsb       = 3;
  localparam int imm_op_lsb   = 11;
  localparam int offset_lsb   = 3;
  localparam int offset_w     = 5;
  localparam int imm8_w       = 8;
  localparam int flag_en_lsb  = 8;
  localparam int polarity_bit = 11;

  // operand b source bits of the latched word
  localparam int b_const_bit  = 15;
  localparam int b_load_bit   = 11;

  // functions with this code bit set update carry
  localparam int carry_op_bit = 2;

  typedef enum logic [3:0] {
    op_pass_a, op_or, op_and, op_xor,
    op_inc, op_dec, op_shl, op_shr,
    op_load_b, op_not_a, op_clear, op_swap,
    op_add, op_sub, op_adc, op_sbb
  } alu_op_t;

  localparam logic [reg_w-1:0] reg_sp = 3'd6;
  localparam logic [reg_w-1:0] reg_ip = 3'd7;

  typedef enum logic [1:0] {
    st_reset, st_select, st_decode, st_compute
  } core_state_t;

  typedef enum logic [3:0] {
    cls_alu_reg, cls_alu_ind, cls_alu_imm16, cls_alu_mem,
    cls_alu_imm8, cls_load_zp, cls_store_zp, cls_load_idx,
    cls_store_idx, cls_store_jump, cls_branch, cls_invalid
  } ir_class_t;

endpackage

`default_nettype wire

/* verilog/cpu16_mem_pkg.sv */
`default_nettype none

package cpu16_mem_pkg;

  localparam int word_w = 16;

  typedef logic [word_w-1:0] word_t;
  typedef logic [word_w-1:0] addr_t;

  // rom occupies the upper half of the word address space
  localparam addr_t rom_base     = 16'h8000;
  localparam addr_t reset_vector = 16'h8000;

  localparam int ram_depth_default = 1024;
  localparam int rom_depth_default = 256;

endpackage

`default_nettype wire

/* verilog/cpu16_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_memory import cpu16_mem_pkg::*; #(
  parameter int ram_depth = ram_depth_default,
  parameter int rom_depth = rom_depth_default
) (
  input  wire        clk,
  mem_bus_if.slave   bus,
  input  wire        load_enable,
  input  wire        load_write,
  input  wire addr_t load_address,
  input  wire word_t load_data
);

  localparam int ram_aw  = $clog2(ram_depth);
  localparam int rom_aw  = $clog2(rom_depth);
  // address bit that selects rom
  localparam int rom_bit = $clog2(rom_base);

  word_t ram [ram_depth];
  word_t rom [rom_depth];

  logic  wr_en;
  addr_t wr_addr;
  word_t wr_data;

  assign bus.rdata = bus.address[rom_bit] ? rom[bus.address[rom_aw-1:0]]
                                          : ram[bus.address[ram_aw-1:0]];

  // load port only runs while the core is idle
  always_comb begin
    if (load_enable && load_write) begin
      wr_en   = 1'b1;
      wr_addr = load_address;
      wr_data = load_data;
    end else begin
      wr_en   = bus.write;
      wr_addr = bus.address;
      wr_data = bus.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (wr_addr[rom_bit])
        rom[wr_addr[rom_aw-1:0]] <= wr_data;
      else
        ram[wr_addr[ram_aw-1:0]] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* verilog/cpu16_system.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu16_system import cpu16_mem_pkg::*; #(
  parameter int ram_depth  = ram_depth_default,
  parameter int rom_depth  = rom_depth_default,
  parameter int data_width = word_w
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        halt,
  input  wire        load_write,
  input  wire addr_t load_address,
  input  wire word_t load_data,
  output wire        busy,
  output wire addr_t address,
  output wire word_t data_out,
  output wire        write
);

  mem_bus_if bus ();

  cpu16_core #(.data_width(data_width)) core_i (
    .clk   (clk),
    .reset (reset),
    .halt  (halt),
    .busy  (busy),
    .bus   (bus.master)
  );

  // program loading is allowed while the core reports busy
  cpu16_memory #(.ram_depth(ram_depth), .rom_depth(rom_depth)) memory_i (
    .clk          (clk),
    .bus          (bus.slave),
    .load_enable  (busy),
    .load_write   (load_write),
    .load_address (load_address),
    .load_data    (load_data)
  );

  assign address  = bus.address;
  assign data_out = bus.wdata;
  assign write    = bus.write;

endmodule

`default_nettype wire
